// ==== build.f ====
common/irq_pkg.sv
rtl/joypad_irq.sv
timer/timer_unit.sv
interrupts/interrupt_flags.sv
rtl/irq_top.sv
tb/irq_tb.sv

// ==== tb/irq_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module irq_tb;

	import irq_pkg::*;

	localparam int joy_sync_stages = 4;
	localparam int reset_cycles    = 16;
	localparam int cycles_per_step = 300;
	localparam int max_steps       = 64;

	localparam int k_write    = 0;
	localparam int k_read     = 1;
	localparam int k_read_min = 2; // Read compared as a lower bound
	localparam int k_pulse    = 3;
	localparam int k_press    = 4;
	localparam int k_release  = 5;
	localparam int k_ack      = 6;
	localparam int k_wait     = 7;

	logic       boga1mhz;
	logic       rst_n;
	logic       psel;
	logic       penable;
	logic       pwrite;
	logic [7:0] paddr;
	logic [7:0] pwdata;
	logic [7:0] prdata;
	logic       pready;
	logic       pslverr;
	logic       p10;
	logic       p11;
	logic       p12;
	logic       p13;
	logic       int_vbl;
	logic       int_stat;
	logic       int_serial;
	logic [4:0] irq_ack;
	logic [4:0] pending;
	logic       wake;

	int         step_kind [max_steps];
	logic [7:0] step_addr [max_steps];
	logic [7:0] step_data [max_steps];
	logic [7:0] step_exp  [max_steps];
	string      step_name [max_steps];
	int         n_steps     = 0;
	int         cycle_cnt   = 0;
	int         cycle_limit = 0;
	integer     seed;

	irq_top #(
		.joy_sync_stages(joy_sync_stages)
	) uut (
		.boga1mhz   (boga1mhz),
		.rst_n      (rst_n),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.paddr      (paddr),
		.pwdata     (pwdata),
		.prdata     (prdata),
		.pready     (pready),
		.pslverr    (pslverr),
		.p10        (p10),
		.p11        (p11),
		.p12        (p12),
		.p13        (p13),
		.int_vbl    (int_vbl),
		.int_stat   (int_stat),
		.int_serial (int_serial),
		.irq_ack    (irq_ack),
		.pending    (pending),
		.wake       (wake)
	);

	initial begin
		boga1mhz = 1'b0;
		forever #2 boga1mhz = ~boga1mhz;
	end

	always @(posedge boga1mhz) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
			$display("timeout after %0d cycles, the step table did not complete", cycle_cnt);
			$display("TEST FAILED");
			$fatal(1);
		end
	end

	// ##################################################
	// Checks and bus tasks
	// ##################################################
	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic check_equal(input string name, input logic [7:0] exp, input logic [7:0] act);
		assert (act === exp) else
			report_failure($sformatf("mismatch %s: expected 0x%02h, actual 0x%02h", name, exp, act));
	endtask

	task automatic add_step(input int kind, input logic [7:0] addr, input logic [7:0] data,
	                        input logic [7:0] exp, input string name);
		step_kind[n_steps] = kind;
		step_addr[n_steps] = addr;
		step_data[n_steps] = data;
		step_exp[n_steps]  = exp;
		step_name[n_steps] = name;
		n_steps++;
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge boga1mhz);
		#1;
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [7:0] data);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b1;
		paddr   = addr;
		pwdata  = data;
		wait_cycles(1);
		penable = 1'b1; // Write lands at the edge that ends the access cycle
		wait_cycles(1);
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [7:0] data, output logic err);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = addr;
		wait_cycles(1);
		penable = 1'b1;
		@(negedge boga1mhz);
		assert (pready === 1'b1) else
			report_failure("pready was low during an APB access cycle");
		data = prdata;
		err  = pslverr;
		wait_cycles(1);
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic check_pending(input string name, input logic [7:0] exp);
		@(negedge boga1mhz);
		check_equal(name, exp, {3'b000, pending});
		wait_cycles(1);
	endtask

	task automatic pulse_line(input logic [7:0] bitpos, input logic [7:0] ack);
		int_vbl    = (bitpos == irq_vblank);
		int_stat   = (bitpos == irq_stat);
		int_serial = (bitpos == irq_serial);
		irq_ack    = ack[4:0]; // Ack in the same cycle as the request
		wait_cycles(1);
		int_vbl    = 1'b0;
		int_stat   = 1'b0;
		int_serial = 1'b0;
		irq_ack    = '0;
	endtask

	task automatic ack_bits(input logic [7:0] mask);
		irq_ack = mask[4:0];
		wait_cycles(1);
		irq_ack = '0;
	endtask

	task automatic press_line(input logic [7:0] line);
		int hold;
		hold = joy_sync_stages + 2 + ($random(seed) & 7);
		{p13, p12, p11, p10} = ~(4'b0001 << line[1:0]);
		wait_cycles(hold);
		@(negedge boga1mhz);
		assert (wake === 1'b1) else
			report_failure("wake did not rise while a P1 line was held low");
		wait_cycles(1);
	endtask

	task automatic release_lines();
		{p13, p12, p11, p10} = 4'hF;
		wait_cycles(joy_sync_stages + 2); // Let the chain drain
		@(negedge boga1mhz);
		assert (wake === 1'b0) else
			report_failure("wake stayed high after all P1 lines were released");
		wait_cycles(1);
	endtask

	// ##################################################
	// Step table and main sequence
	// ##################################################
	initial begin
		logic [7:0] rd;
		logic       err;

		seed = 32'h3936ea89;
		rst_n = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		{p13, p12, p11, p10} = 4'hF;
		int_vbl = 1'b0;
		int_stat = 1'b0;
		int_serial = 1'b0;
		irq_ack = '0;

		add_step(k_wait,  8'h00,     8'd1,  8'h00, "reset_pending");
		add_step(k_read,  addr_if,   8'd0,  8'hE0, "if_after_reset");
		add_step(k_write, addr_ie,   8'h1F, 8'h00, "ie_write");
		add_step(k_read,  addr_ie,   8'd0,  8'h1F, "ie_readback");
		add_step(k_write, addr_tma,  8'h5A, 8'h00, "tma_write");
		add_step(k_read,  addr_tma,  8'd0,  8'h5A, "tma_readback");
		add_step(k_write, addr_tac,  8'h02, 8'h00, "tac_write");
		add_step(k_read,  addr_tac,  8'd0,  8'h02, "tac_readback");
		add_step(k_wait,  8'h00,     8'd250, 8'h00, "div_running"); // Upper DIV byte leaves zero
		add_step(k_write, addr_div,  8'h33, 8'h00, "div_write");
		add_step(k_read,  addr_div,  8'd0,  8'h00, "div_cleared");
		add_step(k_read,  8'h10,     8'd1,  8'h00, "unmapped_read");
		add_step(k_write, 8'h10,     8'h00, 8'h00, "unmapped_write");
		add_step(k_read,  addr_ie,   8'd0,  8'h1F, "ie_untouched");
		add_step(k_pulse, 8'd0,      8'h00, 8'h01, "vbl_pending");
		add_step(k_pulse, 8'd1,      8'h00, 8'h03, "stat_pending");
		add_step(k_pulse, 8'd3,      8'h00, 8'h0B, "serial_pending");
		add_step(k_ack,   8'h02,     8'd0,  8'h09, "ack_stat");
		add_step(k_ack,   8'h01,     8'd0,  8'h08, "ack_vbl");
		add_step(k_ack,   8'h08,     8'd0,  8'h00, "ack_serial");
		add_step(k_write, addr_ie,   8'h00, 8'h00, "ie_mask_all");
		add_step(k_pulse, 8'd1,      8'h00, 8'h00, "masked_pending");
		add_step(k_read,  addr_if,   8'd0,  8'hE2, "masked_if");
		add_step(k_write, addr_if,   8'h00, 8'h00, "if_clear");
		add_step(k_read,  addr_if,   8'd0,  8'hE0, "if_cleared");
		add_step(k_write, addr_ie,   8'h1F, 8'h00, "ie_unmask");
		add_step(k_write, addr_tac,  8'h05, 8'h00, "tac_enable");
		add_step(k_write, addr_tma,  8'h80, 8'h00, "tma_reload");
		add_step(k_write, addr_tima, 8'hFE, 8'h00, "tima_preset");
		add_step(k_wait,  8'h00,     8'd80, 8'h04, "timer_pending");
		add_step(k_read_min, addr_tima, 8'd0, 8'h80, "tima_reloaded");
		add_step(k_ack,   8'h04,     8'd0,  8'h00, "ack_timer");
		add_step(k_write, addr_tac,  8'h01, 8'h00, "tac_disable");
		add_step(k_write, addr_tima, 8'h42, 8'h00, "tima_hold_value");
		add_step(k_wait,  8'h00,     8'd100, 8'h00, "timer_idle");
		add_step(k_read,  addr_tima, 8'd0,  8'h42, "tima_unchanged");
		add_step(k_press, 8'd2,      8'd0,  8'h10, "joypad_pending");
		add_step(k_ack,   8'h10,     8'd0,  8'h00, "ack_joypad");
		add_step(k_wait,  8'h00,     8'd20, 8'h00, "joypad_single_req");
		add_step(k_release, 8'd0,    8'd0,  8'h00, "joypad_release");
		add_step(k_pulse, 8'd0,      8'h00, 8'h01, "vbl_again");
		add_step(k_pulse, 8'd0,      8'h01, 8'h01, "set_wins_clear");
		add_step(k_ack,   8'h01,     8'd0,  8'h00, "ack_vbl_final");

		cycle_limit = n_steps * cycles_per_step + reset_cycles;

		repeat (reset_cycles) @(posedge boga1mhz);
		#1;
		rst_n = 1'b1;

		for (int i = 0; i < n_steps; i++) begin
			case (step_kind[i])
				k_write: apb_write(step_addr[i], step_data[i]);
				k_read: begin
					apb_read(step_addr[i], rd, err);
					check_equal(step_name[i], step_exp[i], rd);
					check_equal({step_name[i], " pslverr"}, step_data[i], {7'd0, err});
				end
				k_read_min: begin
					apb_read(step_addr[i], rd, err);
					assert (rd >= step_exp[i]) else
						report_failure($sformatf("mismatch %s: expected at least 0x%02h, actual 0x%02h",
							step_name[i], step_exp[i], rd));
				end
				k_pulse: begin
					pulse_line(step_addr[i], step_data[i]);
					check_pending(step_name[i], step_exp[i]);
				end
				k_press: begin
					press_line(step_addr[i]);
					check_pending(step_name[i], step_exp[i]);
				end
				k_release: begin
					release_lines();
					check_pending(step_name[i], step_exp[i]);
				end
				k_ack: begin
					ack_bits(step_addr[i]);
					check_pending(step_name[i], step_exp[i]);
				end
				k_wait: begin
					wait_cycles(step_data[i]);
					check_pending(step_name[i], step_exp[i]);
				end
				default: report_failure("the step table holds an unknown step kind");
			endcase
		end

		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire

// ==== rtl/irq_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module irq_top #(
	parameter int joy_sync_stages = 4
) (
	input  logic       boga1mhz,
	input  logic       rst_n,
	input  logic       psel,
	input  logic       penable,
	input  logic       pwrite,
	input  logic [7:0] paddr,
	input  logic [7:0] pwdata,
	output logic [7:0] prdata,
	output logic       pready,
	output logic       pslverr,
	input  logic       p10,
	input  logic       p11,
	input  logic       p12,
	input  logic       p13,
	input  logic       int_vbl,
	input  logic       int_stat,
	input  logic       int_serial,
	input  logic [4:0] irq_ack,
	output logic [4:0] pending,
	output logic       wake
);

	import irq_pkg::*;

	apb_req_t   apb;
	timer_rsp_t timer_rsp;
	logic       timer_req;
	logic       joy_req;

	// APB port bundle
	assign apb.psel    = psel;
	assign apb.penable = penable;
	assign apb.pwrite  = pwrite;
	assign apb.paddr   = paddr;
	assign apb.pwdata  = pwdata;

	// ##################################################
	// Request sources
	// ##################################################
	joypad_irq #(
		.joy_sync_stages(joy_sync_stages)
	) u_joypad (
		.boga1mhz (boga1mhz),
		.rst_n    (rst_n),
		.p10      (p10),
		.p11      (p11),
		.p12      (p12),
		.p13      (p13),
		.joy_req  (joy_req),
		.wake     (wake)
	);

	timer_unit u_timer (
		.boga1mhz  (boga1mhz),
		.rst_n     (rst_n),
		.apb       (apb),
		.rsp       (timer_rsp),
		.timer_req (timer_req)
	);

	// ##################################################
	// IF / IE flag block
	// ##################################################
	interrupt_flags u_flags (
		.boga1mhz   (boga1mhz),
		.rst_n      (rst_n),
		.apb        (apb),
		.rsp        (timer_rsp),
		.int_vbl    (int_vbl),
		.int_stat   (int_stat),
		.int_serial (int_serial),
		.timer_req  (timer_req),
		.joy_req    (joy_req),
		.irq_ack    (irq_ack),
		.pending    (pending),
		.prdata     (prdata),
		.pready     (pready),
		.pslverr    (pslverr)
	);

endmodule

`default_nettype wire

// ==== interrupts/interrupt_flags.sv ====
`timescale 1ns/1ps
`default_nettype none

module interrupt_flags (
	input  logic                boga1mhz,
	input  logic                rst_n,
	input  irq_pkg::apb_req_t   apb,
	input  irq_pkg::timer_rsp_t rsp,
	input  logic                int_vbl,
	input  logic                int_stat,
	input  logic                int_serial,
	input  logic                timer_req,
	input  logic                joy_req,
	input  logic [4:0]          irq_ack,
	output logic [4:0]          pending,
	output logic [7:0]          prdata,
	output logic                pready,
	output logic                pslverr
);

	import irq_pkg::*;

	irq_word_u  req_w;
	irq_word_u  clr_w;
	irq_word_u  wr_w;
	irq_bits_t  if_q;
	irq_bits_t  if_d;
	logic [7:0] ie_q;
	logic       access;
	logic       wr_en;
	logic       if_wr;
	logic       ie_wr;
	logic       hit;
	logic [7:0] rdata;

	assign access = apb.psel && apb.penable;
	assign wr_en  = access && apb.pwrite;
	assign if_wr  = wr_en && (apb.paddr == addr_if);
	assign ie_wr  = wr_en && (apb.paddr == addr_ie);

	// ##################################################
	// Request set, acknowledge clear, CPU write
	// ##################################################
	always_comb begin
		req_w             = '0;
		req_w.bits.vblank = int_vbl;
		req_w.bits.stat   = int_stat;
		req_w.bits.timer  = timer_req;
		req_w.bits.serial = int_serial;
		req_w.bits.joypad = joy_req;

		clr_w             = '0;
		clr_w.bits.vblank = irq_ack[irq_vblank];
		clr_w.bits.stat   = irq_ack[irq_stat];
		clr_w.bits.timer  = irq_ack[irq_timer];
		clr_w.bits.serial = irq_ack[irq_serial];
		clr_w.bits.joypad = irq_ack[irq_joypad];

		wr_w.raw = apb.pwdata;
	end

	always_comb begin
		if (if_wr)
			if_d = wr_w.bits;
		else
			if_d = if_q & ~clr_w.bits;
		if_d        = if_d | req_w.bits; // Requests override ack and write
		if_d.unused = 3'b000;
	end

	always_ff @(posedge boga1mhz or negedge rst_n) begin
		if (!rst_n) begin
			if_q <= '0;
			ie_q <= '0;
		end else begin
			if_q <= if_d;
			if (ie_wr)
				ie_q <= wr_w.raw;
		end
	end

	assign pending = if_q[4:0] & ie_q[4:0];

	// ##################################################
	// APB read mux and error response
	// ##################################################
	always_comb begin
		hit   = 1'b1;
		rdata = 8'h00;
		case (apb.paddr)
			addr_if: rdata = {3'b111, if_q[4:0]}; // Upper bits read as ones
			addr_ie: rdata = ie_q;
			default: begin
				if (rsp.hit)
					rdata = rsp.rdata;
				else
					hit = 1'b0;
			end
		endcase
	end

	assign prdata  = access ? rdata : 8'h00;
	assign pready  = access; // No wait states
	assign pslverr = access && !hit;

	a_no_wait: assert property (
		@(posedge boga1mhz) disable iff (!rst_n)
		(apb.psel && apb.penable) |-> pready
	);

endmodule

`default_nettype wire

// ==== timer/timer_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module timer_unit (
	input  logic                boga1mhz,
	input  logic                rst_n,
	input  irq_pkg::apb_req_t   apb,
	output irq_pkg::timer_rsp_t rsp,
	output logic                timer_req
);

	import irq_pkg::*;

	logic [15:0] div_q;
	logic [7:0]  tima_q;
	logic [7:0]  tma_q;
	logic [2:0]  tac_q;
	logic        sel_bit;
	logic        sel_q;
	logic        tick;
	logic        overflow;
	logic        wr_en;
	logic        wr_div;
	logic        wr_tima;
	logic        wr_tma;
	logic        wr_tac;

	assign wr_en   = apb.psel && apb.penable && apb.pwrite;
	assign wr_div  = wr_en && (apb.paddr == addr_div);
	assign wr_tima = wr_en && (apb.paddr == addr_tima);
	assign wr_tma  = wr_en && (apb.paddr == addr_tma);
	assign wr_tac  = wr_en && (apb.paddr == addr_tac);

	// ##################################################
	// Divider tap select and falling edge detect
	// ##################################################
	always_comb begin
		case (tac_q[1:0])
			2'd0: sel_bit = div_q[9];
			2'd1: sel_bit = div_q[3];
			2'd2: sel_bit = div_q[5];
			default: sel_bit = div_q[7];
		endcase
		sel_bit = sel_bit && tac_q[2]; // Enable gates the tap
	end

	assign tick     = sel_q && !sel_bit;
	assign overflow = tick && (tima_q == 8'hFF) && !wr_tima; // CPU write to TIMA takes priority

	always_ff @(posedge boga1mhz or negedge rst_n) begin
		if (!rst_n) begin
			div_q     <= '0;
			sel_q     <= 1'b0;
			timer_req <= 1'b0;
		end else begin
			sel_q     <= sel_bit;
			timer_req <= overflow;
			if (wr_div)
				div_q <= '0; // Any DIV write clears all 16 bits
			else
				div_q <= div_q + 16'd1;
		end
	end

	always_ff @(posedge boga1mhz or negedge rst_n) begin
		if (!rst_n) begin
			tima_q <= '0;
			tma_q  <= '0;
			tac_q  <= '0;
		end else begin
			if (wr_tma)
				tma_q <= apb.pwdata;
			if (wr_tac)
				tac_q <= apb.pwdata[2:0];
			if (wr_tima)
				tima_q <= apb.pwdata;
			else if (overflow)
				tima_q <= wr_tma ? apb.pwdata : tma_q; // Reload sees a TMA write in flight
			else if (tick)
				tima_q <= tima_q + 8'd1;
		end
	end

	// ##################################################
	// Register read decode
	// ##################################################
	always_comb begin
		rsp.hit   = 1'b1;
		rsp.rdata = 8'h00;
		case (apb.paddr)
			addr_div:  rsp.rdata = div_q[15:8];
			addr_tima: rsp.rdata = tima_q;
			addr_tma:  rsp.rdata = tma_q;
			addr_tac:  rsp.rdata = {5'b00000, tac_q};
			default:   rsp.hit   = 1'b0;
		endcase
	end

	// Request cycle follows a reload from TMA
	a_req_reloaded: assert property (
		@(posedge boga1mhz) disable iff (!rst_n)
		timer_req |-> (tima_q == tma_q)
	);

endmodule

`default_nettype wire

// ==== rtl/joypad_irq.sv ====
`timescale 1ns/1ps
`default_nettype none

module joypad_irq #(
	parameter int joy_sync_stages = 4
) (
	input  logic boga1mhz,
	input  logic rst_n,
	input  logic p10,
	input  logic p11,
	input  logic p12,
	input  logic p13,
	output logic joy_req,
	output logic wake
);

	logic                       pressed;
	logic [joy_sync_stages-1:0] sync_q;
	logic                       last_q;

	assign pressed = !(p10 && p11 && p12 && p13); // Any line pulled low

	// ##################################################
	// Synchronizer and filter chain
	// ##################################################
	always_ff @(posedge boga1mhz or negedge rst_n) begin
		if (!rst_n) begin
			sync_q <= '0;
			last_q <= 1'b0;
		end else begin
			sync_q <= {sync_q[joy_sync_stages-2:0], pressed};
			last_q <= sync_q[joy_sync_stages-1]; // Previous value of last stage
		end
	end

	assign joy_req = sync_q[joy_sync_stages-1] && !last_q; // Rising edge of last stage
	assign wake    = sync_q[0];

	// One press yields a single request cycle
	a_joy_req_single: assert property (
		@(posedge boga1mhz) disable iff (!rst_n)
		joy_req |=> !joy_req
	);

endmodule

`default_nettype wire

// ==== common/irq_pkg.sv ====
`default_nettype none

package irq_pkg;

	// ##################################################
	// Register map, low address byte
	// ##################################################
	localparam logic [7:0] addr_div  = 8'h04;
	localparam logic [7:0] addr_tima = 8'h05;
	localparam logic [7:0] addr_tma  = 8'h06;
	localparam logic [7:0] addr_tac  = 8'h07;
	localparam logic [7:0] addr_if   = 8'h0F;
	localparam logic [7:0] addr_ie   = 8'hFF;

	// ##################################################
	// Request bit positions in IF and IE
	// ##################################################
	localparam int irq_vblank = 0;
	localparam int irq_stat   = 1;
	localparam int irq_timer  = 2;
	localparam int irq_serial = 3;
	localparam int irq_joypad = 4;

	typedef struct packed {
		logic [2:0] unused;
		logic       joypad;
		logic       serial;
		logic       timer;
		logic       stat;
		logic       vblank;
	} irq_bits_t;

	// Same byte seen as a register value or as per-source flags
	typedef union packed {
		logic [7:0] raw;
		irq_bits_t  bits;
	} irq_word_u;

	typedef struct packed {
		logic       psel;
		logic       penable;
		logic       pwrite;
		logic [7:0] paddr;
		logic [7:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic       hit; // Address is one of the timer registers
		logic [7:0] rdata;
	} timer_rsp_t;

endpackage

`default_nettype wire
